// File: alu.sv
`default_nettype none
`include "exeSettings.svh"

module alu
    import exePkg::*;
(
    input  word_t  a_i,
    input  word_t  b_i,
    input  aluOp_e op_i,
    output word_t  result_o,
    output logic   overflow_o
);

    localparam int HALF = `WORD_WIDTH / 2;
    localparam int MSB  = `WORD_WIDTH - 1;

    word_t                   sum;
    word_t                   diff;
    logic [`SHAMT_WIDTH-1:0] shamt;
    logic                    addOv;
    logic                    subOv;

    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;
    assign shamt = a_i[`SHAMT_WIDTH-1:0];  // shifts take the amount from a

    // same-sign inputs, flipped result
    assign addOv = (a_i[MSB] == b_i[MSB]) && (sum[MSB] != a_i[MSB]);
    assign subOv = (a_i[MSB] != b_i[MSB]) && (diff[MSB] != a_i[MSB]);

    always_comb begin
        result_o   = '0;
        overflow_o = 1'b0;
        case (op_i)
            ALU_ADD: begin
                result_o   = sum;
                overflow_o = addOv;
            end
            ALU_ADDU: result_o = sum;
            ALU_SUB: begin
                result_o   = diff;
                overflow_o = subOv;
            end
            ALU_SUBU: result_o = diff;
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_NOR:  result_o = ~(a_i | b_i);
            ALU_SLT:  result_o = word_t'($signed(a_i) < $signed(b_i));
            ALU_SLTU: result_o = word_t'(a_i < b_i);
            ALU_SLL:  result_o = b_i << shamt;
            ALU_SRL:  result_o = b_i >> shamt;
            ALU_SRA:  result_o = word_t'($signed(b_i) >>> shamt);
            ALU_LUI:  result_o = {b_i[HALF-1:0], {HALF{1'b0}}};
            default: begin
                result_o   = '0;
                overflow_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: exceptionCheck.sv
`default_nettype none

module exceptionCheck
    import exePkg::*;
(
    input  word_t     aluRes_i,
    input  word_t     vAddr_i,
    input  logic      overflow_i,
    input  logic      misaligned_i,
    input  logic      decodeExc_i,
    input  excSel_e   excSel_i,
    input  trapKind_e trapKind_i,
    output logic      hasException_o,
    output word_t     badVAddr_o
);

    logic isZero;
    logic trapHit;
    logic localExc;

    assign isZero = (aluRes_i == '0);

    // lt/ge look at the slt result in bit 0
    always_comb begin
        case (trapKind_i)
            TRAP_EQ: trapHit = isZero;
            TRAP_NE: trapHit = !isZero;
            TRAP_LT: trapHit = aluRes_i[0];
            TRAP_GE: trapHit = !aluRes_i[0];
            default: trapHit = 1'b0;
        endcase
    end

    always_comb begin
        case (excSel_i)
            EXC_OVERFLOW: localExc = overflow_i;
            EXC_TRAP:     localExc = trapHit;
            EXC_MEM:      localExc = misaligned_i;
            default:      localExc = 1'b0;
        endcase
    end

    assign hasException_o = localExc || decodeExc_i;

    // fetch-side fault keeps its own address
    assign badVAddr_o = decodeExc_i ? vAddr_i : aluRes_i;

endmodule

`default_nettype wire

// File: exePkg.sv
`default_nettype none
`include "exeSettings.svh"

package exePkg;

    typedef logic [`WORD_WIDTH-1:0]     word_t;
    typedef logic [`REG_NUM_WIDTH-1:0]  regNum_t;
    typedef logic [`FWD_SOURCES-1:0]    fwdSel_t;   // one-hot, bit 0 is the regfile
    typedef logic [`BYTES_PER_WORD-1:0] byteEn_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_ADDU = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_SLL  = 4'd10,
        ALU_SRL  = 4'd11,
        ALU_SRA  = 4'd12,
        ALU_LUI  = 4'd13
    } aluOp_e;

    // code 0 is left unused so an empty payload makes no access
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd1,
        MEM_HALF = 2'd2,
        MEM_WORD = 2'd3
    } memSize_e;

    typedef enum logic [1:0] {
        TRAP_EQ = 2'd0,
        TRAP_NE = 2'd1,
        TRAP_LT = 2'd2,     // also covers the unsigned compare
        TRAP_GE = 2'd3
    } trapKind_e;

    typedef enum logic [1:0] {
        EXC_NONE     = 2'd0,
        EXC_OVERFLOW = 2'd1,
        EXC_TRAP     = 2'd2,
        EXC_MEM      = 2'd3
    } excSel_e;

endpackage

`default_nettype wire

// File: exeSettings.svh
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

`define WORD_WIDTH      32  // data word
`define REG_NUM_WIDTH   5   // gpr number, 0 means no write back
`define SHAMT_WIDTH     5   // shift amount

////////////////////////////////////////////////////////////////////////////
// counts
////////////////////////////////////////////////////////////////////////////

`define FWD_SOURCES     4   // regfile, exe, mem, wb
`define BYTES_PER_WORD  4   // byte lanes on the data bus

`endif

// File: exeStage.sv
`default_nettype none

module exeStage
    import exePkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      idValid_i,
    input  logic      memAllowin_i,
    input  logic      flush_i,
    input  regNum_t   writeNum_i,
    input  word_t     op0_i,
    input  word_t     op1_i,
    input  word_t     regData0_i,
    input  word_t     regData1_i,
    input  word_t     exeFwd_i,
    input  word_t     memFwd_i,
    input  word_t     wbData_i,
    input  word_t     vAddr_i,
    input  logic      op0IsReg_i,
    input  logic      op1IsReg_i,
    input  fwdSel_t   fwdSel0_i,
    input  fwdSel_t   fwdSel1_i,
    input  aluOp_e    aluOp_i,
    input  excSel_e   excSel_i,
    input  trapKind_e trapKind_i,
    input  logic      memReq_i,
    input  logic      memWrite_i,
    input  memSize_e  memSize_i,
    input  logic      decodeExc_i,
    output logic      exeValid_o,
    output logic      allowin_o,
    output regNum_t   writeNum_o,
    output word_t     aluRes_o,
    output byteEn_t   memEnable_o,
    output word_t     storeData_o,
    output logic      hasException_o,
    output word_t     badVAddr_o
);

    localparam int PAYLOAD_WIDTH = $bits(regNum_t) + 7 * $bits(word_t) + 2
                                 + 2 * $bits(fwdSel_t) + $bits(aluOp_e)
                                 + $bits(excSel_e) + $bits(trapKind_e) + 2
                                 + $bits(memSize_e) + 1;

    logic [PAYLOAD_WIDTH-1:0] payloadD;
    logic [PAYLOAD_WIDTH-1:0] payloadQ;

    // registered fields
    regNum_t                    writeNumQ;
    word_t                      op0Q;
    word_t                      op1Q;
    word_t                      regData0Q;
    word_t                      regData1Q;
    word_t                      exeFwdQ;
    word_t                      memFwdQ;
    word_t                      vAddrQ;
    logic                       op0IsRegQ;
    logic                       op1IsRegQ;
    fwdSel_t                    fwdSel0Q;
    fwdSel_t                    fwdSel1Q;
    logic [$bits(aluOp_e)-1:0]    aluOpQ;
    logic [$bits(excSel_e)-1:0]   excSelQ;
    logic [$bits(trapKind_e)-1:0] trapKindQ;
    logic                       memReqQ;
    logic                       memWriteQ;
    logic [$bits(memSize_e)-1:0]  memSizeQ;
    logic                       decodeExcQ;

    // unit outputs
    word_t src0;
    word_t src1;
    word_t regVal0;
    word_t regVal1;
    logic  overflow;
    logic  misaligned;

    ////////////////////////////////////////////////////////////////////////////
    // pipeline register
    ////////////////////////////////////////////////////////////////////////////

    assign payloadD = {writeNum_i, op0_i, op1_i, regData0_i, regData1_i, exeFwd_i,
                       memFwd_i, vAddr_i, op0IsReg_i, op1IsReg_i, fwdSel0_i, fwdSel1_i,
                       aluOp_i, excSel_i, trapKind_i, memReq_i, memWrite_i, memSize_i,
                       decodeExc_i};

    stageReg #(
        .PAYLOAD_WIDTH (PAYLOAD_WIDTH)
    ) stageRegU (
        .clk          (clk),
        .rst          (rst),
        .idValid_i    (idValid_i),
        .memAllowin_i (memAllowin_i),
        .flush_i      (flush_i),
        .payload_i    (payloadD),
        .payload_o    (payloadQ),
        .valid_o      (exeValid_o),
        .allowin_o    (allowin_o)
    );

    assign {writeNumQ, op0Q, op1Q, regData0Q, regData1Q, exeFwdQ, memFwdQ, vAddrQ,
            op0IsRegQ, op1IsRegQ, fwdSel0Q, fwdSel1Q, aluOpQ, excSelQ, trapKindQ,
            memReqQ, memWriteQ, memSizeQ, decodeExcQ} = payloadQ;

    ////////////////////////////////////////////////////////////////////////////
    // execute datapath
    ////////////////////////////////////////////////////////////////////////////

    operandForward operandForwardU (
        .op0_i      (op0Q),
        .op1_i      (op1Q),
        .regData0_i (regData0Q),
        .regData1_i (regData1Q),
        .exeFwd_i   (exeFwdQ),
        .memFwd_i   (memFwdQ),
        .wbData_i   (wbData_i),     // live writeback value
        .op0IsReg_i (op0IsRegQ),
        .op1IsReg_i (op1IsRegQ),
        .fwdSel0_i  (fwdSel0Q),
        .fwdSel1_i  (fwdSel1Q),
        .src0_o     (src0),
        .src1_o     (src1),
        .regVal0_o  (regVal0),
        .regVal1_o  (regVal1)
    );

    alu aluU (
        .a_i        (src0),
        .b_i        (src1),
        .op_i       (aluOp_e'(aluOpQ)),
        .result_o   (aluRes_o),
        .overflow_o (overflow)
    );

    // base from rs, offset is the raw immediate, data from rt
    memAlign memAlignU (
        .base_i       (regVal0),
        .offset_i     (op1Q),
        .storeVal_i   (regVal1),
        .memReq_i     (memReqQ),
        .memWrite_i   (memWriteQ),
        .memSize_i    (memSize_e'(memSizeQ)),
        .memEnable_o  (memEnable_o),
        .storeData_o  (storeData_o),
        .misaligned_o (misaligned)
    );

    exceptionCheck exceptionCheckU (
        .aluRes_i       (aluRes_o),
        .vAddr_i        (vAddrQ),
        .overflow_i     (overflow),
        .misaligned_i   (misaligned),
        .decodeExc_i    (decodeExcQ),
        .excSel_i       (excSel_e'(excSelQ)),
        .trapKind_i     (trapKind_e'(trapKindQ)),
        .hasException_o (hasException_o),
        .badVAddr_o     (badVAddr_o)
    );

    assign writeNum_o = writeNumQ;

endmodule

`default_nettype wire

// File: memAlign.sv
`default_nettype none
`include "exeSettings.svh"

module memAlign
    import exePkg::*;
(
    input  word_t    base_i,
    input  word_t    offset_i,
    input  word_t    storeVal_i,
    input  logic     memReq_i,
    input  logic     memWrite_i,
    input  memSize_e memSize_i,
    output byteEn_t  memEnable_o,
    output word_t    storeData_o,
    output logic     misaligned_o
);

    localparam int LANE_BITS = $clog2(`BYTES_PER_WORD);

    logic [LANE_BITS-1:0] lane;
    word_t                storeRaw;

    // only the low bits of the effective address matter here
    assign lane = base_i[LANE_BITS-1:0] + offset_i[LANE_BITS-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // byte enables and lane replication
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        memEnable_o = '0;
        storeRaw    = '0;
        case (memSize_i)
            MEM_BYTE: begin
                memEnable_o = byteEn_t'(1) << lane;
                storeRaw    = {`BYTES_PER_WORD{storeVal_i[7:0]}};
            end
            MEM_HALF: begin
                if (lane == 0) begin
                    memEnable_o = 4'b0011;
                end else if (lane == 2) begin
                    memEnable_o = 4'b1100;
                end                             // odd offsets get no lanes
                storeRaw = {2{storeVal_i[15:0]}};
            end
            MEM_WORD: begin
                memEnable_o = '1;
                storeRaw    = storeVal_i;
            end
            default: begin
                memEnable_o = '0;
                storeRaw    = '0;
            end
        endcase
    end

    assign storeData_o = memWrite_i ? storeRaw : '0;   // loads carry no data

    assign misaligned_o = memReq_i &&
                          (((memSize_i == MEM_HALF) && lane[0]) ||
                           ((memSize_i == MEM_WORD) && (lane != 0)));

endmodule

`default_nettype wire

// File: operandForward.sv
`default_nettype none
`include "exeSettings.svh"

module operandForward
    import exePkg::*;
(
    input  word_t   op0_i,
    input  word_t   op1_i,
    input  word_t   regData0_i,
    input  word_t   regData1_i,
    input  word_t   exeFwd_i,
    input  word_t   memFwd_i,
    input  word_t   wbData_i,       // straight from writeback, not registered
    input  logic    op0IsReg_i,
    input  logic    op1IsReg_i,
    input  fwdSel_t fwdSel0_i,
    input  fwdSel_t fwdSel1_i,
    output word_t   src0_o,
    output word_t   src1_o,
    output word_t   regVal0_o,
    output word_t   regVal1_o
);

    // and-or mux over the one-hot select
    function automatic word_t pickSource(input fwdSel_t sel, input word_t regData,
                                         input word_t exeFwd, input word_t memFwd,
                                         input word_t wbData);
        word_t cand [`FWD_SOURCES];
        word_t acc;
        cand[0] = regData;
        cand[1] = exeFwd;
        cand[2] = memFwd;
        cand[3] = wbData;
        acc     = '0;
        for (int i = 0; i < `FWD_SOURCES; i++) begin
            acc |= cand[i] & {`WORD_WIDTH{sel[i]}};
        end
        return acc;
    endfunction

    assign regVal0_o = pickSource(fwdSel0_i, regData0_i, exeFwd_i, memFwd_i, wbData_i);
    assign regVal1_o = pickSource(fwdSel1_i, regData1_i, exeFwd_i, memFwd_i, wbData_i);

    // immediate otherwise
    assign src0_o = op0IsReg_i ? regVal0_o : op0_i;
    assign src1_o = op1IsReg_i ? regVal1_o : op1_i;

endmodule

`default_nettype wire

// File: src.f
+incdir+.
exePkg.sv
stageReg.sv
operandForward.sv
alu.sv
memAlign.sv
exceptionCheck.sv
exeStage.sv
tb_exeStage.sv

// File: stageReg.sv
`default_nettype none

module stageReg #(
    parameter int PAYLOAD_WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     idValid_i,
    input  logic                     memAllowin_i,
    input  logic                     flush_i,
    input  logic [PAYLOAD_WIDTH-1:0] payload_i,
    output logic [PAYLOAD_WIDTH-1:0] payload_o,
    output logic                     valid_o,
    output logic                     allowin_o
);

    logic                     hasData;
    logic [PAYLOAD_WIDTH-1:0] payloadQ;
    logic                     accept;
    logic                     drain;

    // free slot, or the current one leaves this edge
    assign allowin_o = !hasData || memAllowin_i;

    assign accept = idValid_i && allowin_o;
    assign drain  = !idValid_i && allowin_o;   // nothing coming in, go empty

    ////////////////////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst || flush_i || drain) begin     // flush wins over acceptance
            hasData  <= 1'b0;
            payloadQ <= '0;
        end else if (accept) begin
            hasData  <= 1'b1;
            payloadQ <= payload_i;
        end
    end

    assign valid_o   = hasData;
    assign payload_o = payloadQ;

endmodule

`default_nettype wire

// File: tb_exeStage.sv
`default_nettype none

module tb_exeStage
    import exePkg::*;
();

    localparam word_t    REG0   = 32'h0000_1234;   // regfile, operand 0
    localparam word_t    REG1   = 32'h8765_00ab;   // regfile, operand 1
    localparam word_t    EXEF   = 32'h00c0_0000;
    localparam word_t    MEMF   = 32'h0000_0500;
    localparam word_t    VADDR  = 32'h0040_bad0;
    localparam memSize_e NOSIZE = memSize_e'(2'd0); // no access

    // one row of the stimulus and expected-value table
    typedef struct packed {
        aluOp_e    aluOp;
        word_t     op0;
        word_t     op1;
        logic [1:0] isReg;      // bit 1 op1, bit 0 op0
        fwdSel_t   sel0;
        fwdSel_t   sel1;
        excSel_e   excSel;
        trapKind_e trap;
        logic [1:0] mem;        // {req, write}
        memSize_e  size;
        logic      decExc;
        logic      useWb;       // result is the live writeback value
        word_t     expRes;
        logic      expExc;
        byteEn_t   expEn;
        word_t     expStore;
    } entry_t;

    logic      clk;
    logic      rst;
    logic      idValid_i;
    logic      memAllowin_i;
    logic      flush_i;
    regNum_t   writeNum_i;
    word_t     op0_i;
    word_t     op1_i;
    word_t     regData0_i;
    word_t     regData1_i;
    word_t     exeFwd_i;
    word_t     memFwd_i;
    word_t     wbData_i;
    word_t     vAddr_i;
    logic      op0IsReg_i;
    logic      op1IsReg_i;
    fwdSel_t   fwdSel0_i;
    fwdSel_t   fwdSel1_i;
    aluOp_e    aluOp_i;
    excSel_e   excSel_i;
    trapKind_e trapKind_i;
    logic      memReq_i;
    logic      memWrite_i;
    memSize_e  memSize_i;
    logic      decodeExc_i;
    logic      exeValid_o;
    logic      allowin_o;
    regNum_t   writeNum_o;
    word_t     aluRes_o;
    byteEn_t   memEnable_o;
    word_t     storeData_o;
    logic      hasException_o;
    word_t     badVAddr_o;

    entry_t cases [$];
    string  names [$];
    integer seed;
    int     cycleCount;
    int     cycleLimit;

    exeStage uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, the stage stopped making progress", cycleCount);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic addCase(input string name, input entry_t e);
        names.push_back(name);
        cases.push_back(e);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // table
    ////////////////////////////////////////////////////////////////////////////

    task automatic buildTable();
        addCase("add", '{ALU_ADD, 32'h5, 32'h7, 2'b00, 4'h1, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'hc, 1'b0, 4'h0, 32'h0});
        addCase("addu", '{ALU_ADDU, 32'hffffffff, 32'h2, 2'b00, 4'h1, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'h1, 1'b0, 4'h0, 32'h0});
        addCase("sub", '{ALU_SUB, 32'ha, 32'h3, 2'b00, 4'h1, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'h7, 1'b0, 4'h0, 32'h0});
        addCase("subu", '{ALU_SUBU, 32'h3, 32'h5, 2'b00, 4'h1, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'hfffffffe, 1'b0, 4'h0, 32'h0});
        addCase("and", '{ALU_AND, 32'hff00ff00, 32'h0f0f0f0f, 2'b00, 4'h1, 4'h1, EXC_NONE,
                TRAP_EQ, 2'b00, NOSIZE, 1'b0, 1'b0, 32'h0f000f00, 1'b0, 4'h0, 32'h0});
        addCase("or", '{ALU_OR, 32'hff00ff00, 32'h0f0f0f0f, 2'b00, 4'h1, 4'h1, EXC_NONE,
                TRAP_EQ, 2'b00, NOSIZE, 1'b0, 1'b0, 32'hff0fff0f, 1'b0, 4'h0, 32'h0});
        addCase("xor", '{ALU_XOR, 32'hff00ff00, 32'h0f0f0f0f, 2'b00, 4'h1, 4'h1, EXC_NONE,
                TRAP_EQ, 2'b00, NOSIZE, 1'b0, 1'b0, 32'hf00ff00f, 1'b0, 4'h0, 32'h0});
        addCase("nor", '{ALU_NOR, 32'hff00ff00, 32'h0f0f0f0f, 2'b00, 4'h1, 4'h1, EXC_NONE,
                TRAP_EQ, 2'b00, NOSIZE, 1'b0, 1'b0, 32'h00f000f0, 1'b0, 4'h0, 32'h0});
        addCase("slt", '{ALU_SLT, 32'hfffffffe, 32'h1, 2'b00, 4'h1, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'h1, 1'b0, 4'h0, 32'h0});
        addCase("sltu", '{ALU_SLTU, 32'hfffffffe, 32'h1, 2'b00, 4'h1, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'h0, 1'b0, 4'h0, 32'h0});
        addCase("sll", '{ALU_SLL, 32'h4, 32'hf1, 2'b00, 4'h1, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'hf10, 1'b0, 4'h0, 32'h0});
        addCase("srl", '{ALU_SRL, 32'h8, 32'hf0000000, 2'b00, 4'h1, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'h00f00000, 1'b0, 4'h0, 32'h0});
        addCase("sra", '{ALU_SRA, 32'h8, 32'hf0000000, 2'b00, 4'h1, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'hfff00000, 1'b0, 4'h0, 32'h0});
        addCase("lui", '{ALU_LUI, 32'h0, 32'h1234, 2'b00, 4'h1, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'h12340000, 1'b0, 4'h0, 32'h0});
        // forwarding, the other operand is an immediate zero
        addCase("fwd0 regfile", '{ALU_ADDU, 32'h0, 32'h0, 2'b01, 4'h1, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, REG0, 1'b0, 4'h0, 32'h0});
        addCase("fwd0 exe", '{ALU_ADDU, 32'h0, 32'h0, 2'b01, 4'h2, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, EXEF, 1'b0, 4'h0, 32'h0});
        addCase("fwd0 mem", '{ALU_ADDU, 32'h0, 32'h0, 2'b01, 4'h4, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, MEMF, 1'b0, 4'h0, 32'h0});
        addCase("fwd0 wb", '{ALU_ADDU, 32'h0, 32'h0, 2'b01, 4'h8, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b1, 32'h0, 1'b0, 4'h0, 32'h0});
        addCase("fwd1 regfile", '{ALU_ADDU, 32'h0, 32'h0, 2'b10, 4'h1, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, REG1, 1'b0, 4'h0, 32'h0});
        addCase("fwd1 exe", '{ALU_ADDU, 32'h0, 32'h0, 2'b10, 4'h1, 4'h2, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, EXEF, 1'b0, 4'h0, 32'h0});
        addCase("fwd1 mem", '{ALU_ADDU, 32'h0, 32'h0, 2'b10, 4'h1, 4'h4, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, MEMF, 1'b0, 4'h0, 32'h0});
        addCase("fwd1 wb", '{ALU_ADDU, 32'h0, 32'h0, 2'b10, 4'h1, 4'h8, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b1, 32'h0, 1'b0, 4'h0, 32'h0});
        // stores, base REG0 is word aligned, data from REG1
        addCase("sb lane0", '{ALU_ADDU, 32'h0, 32'h0, 2'b01, 4'h1, 4'h1, EXC_MEM, TRAP_EQ,
                2'b11, MEM_BYTE, 1'b0, 1'b0, 32'h1234, 1'b0, 4'h1, 32'habababab});
        addCase("sb lane1", '{ALU_ADDU, 32'h0, 32'h1, 2'b01, 4'h1, 4'h1, EXC_MEM, TRAP_EQ,
                2'b11, MEM_BYTE, 1'b0, 1'b0, 32'h1235, 1'b0, 4'h2, 32'habababab});
        addCase("sb lane2", '{ALU_ADDU, 32'h0, 32'h2, 2'b01, 4'h1, 4'h1, EXC_MEM, TRAP_EQ,
                2'b11, MEM_BYTE, 1'b0, 1'b0, 32'h1236, 1'b0, 4'h4, 32'habababab});
        addCase("sb lane3", '{ALU_ADDU, 32'h0, 32'h3, 2'b01, 4'h1, 4'h1, EXC_MEM, TRAP_EQ,
                2'b11, MEM_BYTE, 1'b0, 1'b0, 32'h1237, 1'b0, 4'h8, 32'habababab});
        addCase("sh off0", '{ALU_ADDU, 32'h0, 32'h0, 2'b01, 4'h1, 4'h1, EXC_MEM, TRAP_EQ,
                2'b11, MEM_HALF, 1'b0, 1'b0, 32'h1234, 1'b0, 4'h3, 32'h00ab00ab});
        addCase("sh off2", '{ALU_ADDU, 32'h0, 32'h2, 2'b01, 4'h1, 4'h1, EXC_MEM, TRAP_EQ,
                2'b11, MEM_HALF, 1'b0, 1'b0, 32'h1236, 1'b0, 4'hc, 32'h00ab00ab});
        addCase("sw", '{ALU_ADDU, 32'h0, 32'h0, 2'b01, 4'h1, 4'h1, EXC_MEM, TRAP_EQ,
                2'b11, MEM_WORD, 1'b0, 1'b0, 32'h1234, 1'b0, 4'hf, REG1});
        // exceptions
        addCase("add overflow", '{ALU_ADD, 32'h7fffffff, 32'h1, 2'b00, 4'h1, 4'h1, EXC_OVERFLOW,
                TRAP_EQ, 2'b00, NOSIZE, 1'b0, 1'b0, 32'h80000000, 1'b1, 4'h0, 32'h0});
        addCase("addu no trap", '{ALU_ADDU, 32'h7fffffff, 32'h1, 2'b00, 4'h1, 4'h1, EXC_OVERFLOW,
                TRAP_EQ, 2'b00, NOSIZE, 1'b0, 1'b0, 32'h80000000, 1'b0, 4'h0, 32'h0});
        addCase("teq taken", '{ALU_SUBU, 32'h5, 32'h5, 2'b00, 4'h1, 4'h1, EXC_TRAP, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'h0, 1'b1, 4'h0, 32'h0});
        addCase("teq not taken", '{ALU_SUBU, 32'h5, 32'h4, 2'b00, 4'h1, 4'h1, EXC_TRAP, TRAP_EQ,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'h1, 1'b0, 4'h0, 32'h0});
        addCase("tne taken", '{ALU_SUBU, 32'h5, 32'h4, 2'b00, 4'h1, 4'h1, EXC_TRAP, TRAP_NE,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'h1, 1'b1, 4'h0, 32'h0});
        addCase("tne not taken", '{ALU_SUBU, 32'h5, 32'h5, 2'b00, 4'h1, 4'h1, EXC_TRAP, TRAP_NE,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'h0, 1'b0, 4'h0, 32'h0});
        addCase("tlt taken", '{ALU_SLT, 32'hfffffffe, 32'h1, 2'b00, 4'h1, 4'h1, EXC_TRAP, TRAP_LT,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'h1, 1'b1, 4'h0, 32'h0});
        addCase("tlt not taken", '{ALU_SLT, 32'h1, 32'hfffffffe, 2'b00, 4'h1, 4'h1, EXC_TRAP,
                TRAP_LT, 2'b00, NOSIZE, 1'b0, 1'b0, 32'h0, 1'b0, 4'h0, 32'h0});
        addCase("tge taken", '{ALU_SLT, 32'h1, 32'hfffffffe, 2'b00, 4'h1, 4'h1, EXC_TRAP, TRAP_GE,
                2'b00, NOSIZE, 1'b0, 1'b0, 32'h0, 1'b1, 4'h0, 32'h0});
        addCase("tge not taken", '{ALU_SLT, 32'hfffffffe, 32'h1, 2'b00, 4'h1, 4'h1, EXC_TRAP,
                TRAP_GE, 2'b00, NOSIZE, 1'b0, 1'b0, 32'h1, 1'b0, 4'h0, 32'h0});
        addCase("lh misaligned", '{ALU_ADDU, 32'h0, 32'h1, 2'b01, 4'h1, 4'h1, EXC_MEM, TRAP_EQ,
                2'b10, MEM_HALF, 1'b0, 1'b0, 32'h1235, 1'b1, 4'h0, 32'h0});
        addCase("lw misaligned", '{ALU_ADDU, 32'h0, 32'h2, 2'b01, 4'h1, 4'h1, EXC_MEM, TRAP_EQ,
                2'b10, MEM_WORD, 1'b0, 1'b0, 32'h1236, 1'b1, 4'hf, 32'h0});
        addCase("decode exc", '{ALU_ADDU, 32'h1, 32'h2, 2'b00, 4'h1, 4'h1, EXC_NONE, TRAP_EQ,
                2'b00, NOSIZE, 1'b1, 1'b0, 32'h3, 1'b1, 4'h0, 32'h0});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // drive and check
    ////////////////////////////////////////////////////////////////////////////

    task automatic driveCase(input int idx, input word_t wb);
        entry_t e;
        e = cases[idx];
        idValid_i   <= 1'b1;
        writeNum_i  <= regNum_t'(idx + 1);
        op0_i       <= e.op0;
        op1_i       <= e.op1;
        op0IsReg_i  <= e.isReg[0];
        op1IsReg_i  <= e.isReg[1];
        fwdSel0_i   <= e.sel0;
        fwdSel1_i   <= e.sel1;
        aluOp_i     <= e.aluOp;
        excSel_i    <= e.excSel;
        trapKind_i  <= e.trap;
        memReq_i    <= e.mem[1];
        memWrite_i  <= e.mem[0];
        memSize_i   <= e.size;
        decodeExc_i <= e.decExc;
        wbData_i    <= wb;
    endtask

    // returns on the edge that took the instruction
    task automatic waitAccept();
        @(negedge clk);
        while (!allowin_o) @(negedge clk);
        @(posedge clk);
        idValid_i <= 1'b0;
    endtask

    task automatic applyCase(input int idx);
        entry_t e;
        word_t  wb;
        word_t  expRes;
        word_t  expBad;
        string  n;
        e      = cases[idx];
        n      = names[idx];
        wb     = $random(seed);
        expRes = e.useWb ? wb : e.expRes;  // wb plus an immediate zero
        expBad = e.decExc ? VADDR : expRes;
        @(posedge clk);
        driveCase(idx, wb);
        waitAccept();
        if (idx % 6 == 2) begin            // hold the result with back-pressure
            memAllowin_i <= 1'b0;
            repeat (3) begin
                @(negedge clk);
                checkValue({n, " stall allowin"}, 0, allowin_o);
                checkValue({n, " stall valid"}, 1, exeValid_o);
                checkValue({n, " stall aluRes"}, expRes, aluRes_o);
                @(posedge clk);
            end
            memAllowin_i <= 1'b1;
        end
        @(negedge clk);
        checkValue({n, " exeValid"}, 1, exeValid_o);
        checkValue({n, " aluRes"}, expRes, aluRes_o);
        checkValue({n, " hasException"}, e.expExc, hasException_o);
        checkValue({n, " memEnable"}, e.expEn, memEnable_o);
        checkValue({n, " storeData"}, e.expStore, storeData_o);
        checkValue({n, " badVAddr"}, expBad, badVAddr_o);
        checkValue({n, " writeNum"}, regNum_t'(idx + 1), writeNum_o);
    endtask

    initial begin
        seed         = 32'h177d;
        cycleCount   = 0;
        rst          = 1'b0;
        idValid_i    = 1'b0;
        memAllowin_i = 1'b1;
        flush_i      = 1'b0;
        writeNum_i   = '0;
        op0_i        = '0;
        op1_i        = '0;
        regData0_i   = REG0;
        regData1_i   = REG1;
        exeFwd_i     = EXEF;
        memFwd_i     = MEMF;
        wbData_i     = '0;
        vAddr_i      = VADDR;
        op0IsReg_i   = 1'b0;
        op1IsReg_i   = 1'b0;
        fwdSel0_i    = 4'h1;
        fwdSel1_i    = 4'h1;
        aluOp_i      = ALU_ADD;
        excSel_i     = EXC_NONE;
        trapKind_i   = TRAP_EQ;
        memReq_i     = 1'b0;
        memWrite_i   = 1'b0;
        memSize_i    = NOSIZE;
        decodeExc_i  = 1'b0;
        buildTable();
        cycleLimit = 20 * cases.size() + 100;

        repeat (10) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        checkValue("reset exeValid", 0, exeValid_o);
        checkValue("reset allowin", 1, allowin_o);
        checkValue("reset aluRes", 0, aluRes_o);
        checkValue("reset writeNum", 0, writeNum_o);
        checkValue("reset memEnable", 0, memEnable_o);

        for (int i = 0; i < cases.size(); i++) begin
            applyCase(i);
        end

        // flush of a held instruction
        @(posedge clk);
        driveCase(0, '0);
        waitAccept();
        memAllowin_i <= 1'b0;
        @(negedge clk);
        checkValue("flush held valid", 1, exeValid_o);
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i      <= 1'b0;
        memAllowin_i <= 1'b1;
        @(negedge clk);
        checkValue("flush exeValid", 0, exeValid_o);
        checkValue("flush aluRes", 0, aluRes_o);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
